// ==== filelist.f ====
common/uart_cfg_pkg.sv
common/uart_state_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_status.sv
source/uart_core.sv
sim/tb_clock_gen.sv
sim/tb_uart_core.sv

// ==== Bender.yml ====
package:
  name: uart_core

sources:
  - common/uart_cfg_pkg.sv
  - common/uart_state_pkg.sv
  - source/uart_rx.sv
  - source/uart_tx.sv
  - source/uart_status.sv
  - source/uart_core.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_uart_core.sv

// ==== sim/tb_uart_core.sv ====
/*
 * Testbench for the UART core. Loops the transmitter back into the receiver,
 * drives hand-made frames and checks the line and status against a frame model.
 */
module tb_uart_core;
    import uart_cfg_pkg::*;
    import uart_state_pkg::*;

    localparam int DATA_BITS = 8;
    // Status bit masks in the order of the packed struct
    localparam logic [3:0] RDY  = 4'b1000;
    localparam logic [3:0] OVR  = 4'b0100;
    localparam logic [3:0] FERR = 4'b0010;
    localparam logic [3:0] BUSY = 4'b0001;

    logic                  clk;
    logic                  rst_n;
    logic                  rx_line;
    logic                  tx_line;
    logic                  loopback;
    logic                  manual_line;
    baud_div_t             baud_div;
    logic                  tx_start;
    logic [DATA_BITS-1:0]  tx_data;
    logic                  rd_ack;
    logic                  clr_err;
    logic [DATA_BITS-1:0]  rx_data;
    uart_status_t          status;
    logic [3:0]            status_bits;
    logic [3:0]            prev_bits = '0;
    logic [DATA_BITS-1:0]  exp_q[$];
    int                    error_count = 0;
    int                    timeout_count = 0;
    integer                seed;

    tb_clock_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    // Receiver line comes from our own transmitter or from the testbench
    assign rx_line     = loopback ? tx_line : manual_line;
    assign status_bits = status;

    uart_core #(.DATA_BITS(DATA_BITS)) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_i       (rx_line),
        .tx_o       (tx_line),
        .baud_div_i (baud_div),
        .tx_start_i (tx_start),
        .tx_data_i  (tx_data),
        .rd_ack_i   (rd_ack),
        .clr_err_i  (clr_err),
        .rx_data_o  (rx_data),
        .status_o   (status)
    );

    // Expected line level of bit idx within a frame (start, data LSB first, stop)
    function automatic logic expected_frame(input logic [DATA_BITS-1:0] word, input int idx);
        logic level;
        if (idx == 0) begin
            level = 1'b0;
        end else if (idx <= DATA_BITS) begin
            level = word[idx-1];
        end else begin
            level = 1'b1;
        end
        return level;
    endfunction

    function automatic logic [DATA_BITS-1:0] random_word();
        integer r;
        r = $random(seed);
        return r[DATA_BITS-1:0];
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic finish_run();
        $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // Wait until the masked status bits read the given value
    task automatic wait_status(input logic [3:0] mask, input logic [3:0] value,
                               input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((status_bits & mask) !== value &&
               cycles < 4 * (DATA_BITS + 2) * baud_div) begin
            @(negedge clk);
            cycles++;
        end
        if ((status_bits & mask) !== value) begin
            $display("Timeout: %s", what);
            timeout_count++;
            finish_run();
        end
    endtask

    task automatic start_tx(input logic [DATA_BITS-1:0] word);
        @(posedge clk);
        tx_data  <= word;
        tx_start <= 1'b1;
        @(posedge clk);
        tx_start <= 1'b0;
    endtask

    task automatic pulse_host(input logic ack, input logic clr);
        @(posedge clk);
        rd_ack  <= ack;
        clr_err <= clr;
        @(posedge clk);
        rd_ack  <= 1'b0;
        clr_err <= 1'b0;
    endtask

    // Send one word and check the line in the middle of every bit period
    task automatic send_checked_word(input logic [DATA_BITS-1:0] word);
        int k;
        exp_q.push_back(word);
        start_tx(word);
        wait_status(BUSY, BUSY, "transmitter never became busy");
        repeat (baud_div / 2) @(negedge clk);
        for (k = 0; k < DATA_BITS + 2; k++) begin
            if (tx_line !== expected_frame(word, k) || !status.tx_busy) begin
                report_error($sformatf("bit %0d of word %h: tx %b busy %b",
                                       k, word, tx_line, status.tx_busy));
            end
            repeat (baud_div) @(negedge clk);
        end
        wait_status(BUSY, 4'b0000, "transmitter stayed busy after the stop bit");
    endtask

    task automatic run_loopback(input int count);
        repeat (count) begin
            send_checked_word(random_word());
            wait_status(RDY, RDY, "no word arrived at the receiver");
            if (status.overrun || status.frame_err) begin
                report_error("error flag set during loopback");
            end
            pulse_host(1'b1, 1'b0);
            @(negedge clk);
            if (status.rx_ready) begin
                report_error("rx_ready still set after rd_ack");
            end
        end
    endtask

    // Every new word in the holding register must be the oldest one sent
    always @(negedge clk) begin : compare_words
        logic [DATA_BITS-1:0] exp_word;
        if (rst_n && (status_bits & ~prev_bits & (RDY | OVR)) != 4'b0000) begin
            if (exp_q.size() == 0) begin
                report_error($sformatf("unexpected word %h received", rx_data));
            end else begin
                exp_word = exp_q.pop_front();
                if (rx_data !== exp_word) begin
                    report_error($sformatf("received %h, expected %h", rx_data, exp_word));
                end
            end
        end
        prev_bits = status_bits;
    end

    initial begin : main
        logic [DATA_BITS-1:0] word;
        int k;
        int cycles;
        seed        = 43070;
        loopback    = 1'b1;
        manual_line = 1'b1;
        baud_div    = baud_div_t'(10);
        tx_start    = 1'b0;
        tx_data     = '0;
        rd_ack      = 1'b0;
        clr_err     = 1'b0;
        cycles      = 0;
        while (rst_n !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            timeout_count++;
            finish_run();
        end
        @(negedge clk);
        if (tx_line !== 1'b1 || status_bits !== 4'b0000 || rx_data !== '0) begin
            report_error("outputs not at their reset values");
        end

        run_loopback(20);

        // Hand-driven frame with the stop bit forced low
        word = random_word();
        @(posedge clk);
        loopback <= 1'b0;
        for (k = 0; k <= DATA_BITS + 1; k++) begin
            @(posedge clk);
            manual_line <= (k <= DATA_BITS) ? expected_frame(word, k) : 1'b0;
            repeat (baud_div - 1) @(posedge clk);
        end
        @(posedge clk);
        manual_line <= 1'b1;
        wait_status(FERR, FERR, "frame error flag was never set");
        repeat (2 * baud_div) @(negedge clk);
        if (status.rx_ready) begin
            report_error("rx_ready set by a frame with a low stop bit");
        end
        pulse_host(1'b0, 1'b1);
        @(negedge clk);
        if (status.frame_err) begin
            report_error("frame_err still set after clr_err");
        end
        @(posedge clk);
        loopback <= 1'b1;

        // Two words with no read in between
        send_checked_word(random_word());
        wait_status(RDY, RDY, "first word of the overrun pair never arrived");
        word = random_word();
        send_checked_word(word);
        wait_status(OVR, OVR, "overrun flag was never set");
        if (!status.rx_ready || rx_data !== word) begin
            report_error($sformatf("after overrun rx_data %h, expected %h", rx_data, word));
        end
        pulse_host(1'b1, 1'b1);
        @(negedge clk);
        if (status.rx_ready || status.overrun) begin
            report_error("flags not cleared by rd_ack and clr_err");
        end

        // Start strobe while busy must be dropped
        word = random_word();
        exp_q.push_back(word);
        start_tx(word);
        wait_status(BUSY, BUSY, "transmitter never became busy");
        start_tx(~word);
        wait_status(RDY, RDY, "first word never arrived during busy test");
        wait_status(BUSY, 4'b0000, "transmitter stayed busy after one frame");
        repeat (2) @(negedge clk);
        if (status.tx_busy) begin
            report_error("start strobe during a frame was queued");
        end
        pulse_host(1'b1, 1'b0);
        repeat ((DATA_BITS + 3) * baud_div) @(negedge clk);
        if (status.rx_ready) begin
            report_error("a second word reached the receiver");
        end

        @(posedge clk);
        baud_div <= baud_div_t'(7);
        run_loopback(20);
        @(posedge clk);
        baud_div <= baud_div_t'(16);
        run_loopback(20);

        if (exp_q.size() != 0) begin
            $display("%0d sent words never reached the receiver", exp_q.size());
            error_count++;
        end
        finish_run();
    end

endmodule

// ==== sim/tb_clock_gen.sv ====
/*
 * Free-running testbench clock and power-on reset for the UART testbench.
 */
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // Period of 100 time units
    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o;
        end
    end

    // Reset held low for the first 8 cycles
    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// ==== source/uart_core.sv ====
/*
 * UART top level. Receiver, transmitter and status unit side by side,
 * sharing one run-time baud divisor.
 */
module uart_core #(
    parameter int unsigned DATA_BITS = uart_cfg_pkg::UART_DEFAULT_DATA_BITS
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // Serial lines
    input  logic                          rx_i,
    output logic                          tx_o,
    // Cycles per bit, at least 4
    input  uart_cfg_pkg::baud_div_t       baud_div_i,
    // Transmit request, ignored while busy
    input  logic                          tx_start_i,
    input  logic [DATA_BITS-1:0]          tx_data_i,
    // Host side of the receive path
    input  logic                          rd_ack_i,
    input  logic                          clr_err_i,
    output logic [DATA_BITS-1:0]          rx_data_o,
    output uart_state_pkg::uart_status_t  status_o
);

    logic                  rx_valid;
    logic                  rx_frame_err;
    logic [DATA_BITS-1:0]  rx_word;
    logic                  tx_busy;

    uart_rx #(.DATA_BITS(DATA_BITS)) u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_i        (rx_i),
        .baud_div_i  (baud_div_i),
        .rx_data_o   (rx_word),
        .valid_o     (rx_valid),
        .frame_err_o (rx_frame_err)
    );

    uart_tx #(.DATA_BITS(DATA_BITS)) u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (tx_start_i),
        .data_i     (tx_data_i),
        .baud_div_i (baud_div_i),
        .tx_o       (tx_o),
        .busy_o     (tx_busy)
    );

    uart_status #(.DATA_BITS(DATA_BITS)) u_status (
        .clk            (clk),
        .rst_n          (rst_n),
        .rx_valid_i     (rx_valid),
        .rx_frame_err_i (rx_frame_err),
        .rx_data_i      (rx_word),
        .tx_busy_i      (tx_busy),
        .rd_ack_i       (rd_ack_i),
        .clr_err_i      (clr_err_i),
        .rx_data_o      (rx_data_o),
        .status_o       (status_o)
    );

endmodule

// ==== source/uart_status.sv ====
/*
 * Receive holding register with ready flag, sticky error flags and
 * transmitter activity, reported together as one status word.
 */
module uart_status #(
    parameter int unsigned DATA_BITS = uart_cfg_pkg::UART_DEFAULT_DATA_BITS
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          rx_valid_i,
    input  logic                          rx_frame_err_i,
    input  logic [DATA_BITS-1:0]          rx_data_i,
    input  logic                          tx_busy_i,
    input  logic                          rd_ack_i,
    input  logic                          clr_err_i,
    output logic [DATA_BITS-1:0]          rx_data_o,
    output uart_state_pkg::uart_status_t  status_o
);

    logic [DATA_BITS-1:0]  hold_ff;
    logic                  ready_ff;
    logic                  overrun_ff;
    logic                  frame_err_ff;

    // Holding register, written on every good frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_ff <= '0;
        end else if (rx_valid_i) begin
            hold_ff <= rx_data_i;
        end
    end

    // Flags; a set in the same cycle as a clear takes priority
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_ff     <= 1'b0;
            overrun_ff   <= 1'b0;
            frame_err_ff <= 1'b0;
        end else begin
            if (rx_valid_i) begin
                ready_ff <= 1'b1;
            end else if (rd_ack_i) begin
                ready_ff <= 1'b0;
            end

            // New word while the old one is still unread
            if (rx_valid_i && ready_ff) begin
                overrun_ff <= 1'b1;
            end else if (clr_err_i) begin
                overrun_ff <= 1'b0;
            end

            if (rx_frame_err_i) begin
                frame_err_ff <= 1'b1;
            end else if (clr_err_i) begin
                frame_err_ff <= 1'b0;
            end
        end
    end

    assign rx_data_o = hold_ff;

    always_comb begin
        status_o.rx_ready  = ready_ff;
        status_o.overrun   = overrun_ff;
        status_o.frame_err = frame_err_ff;
        status_o.tx_busy   = tx_busy_i;
    end

endmodule

// ==== source/uart_tx.sv ====
/*
 * UART transmitter. A start strobe while idle sends one frame:
 * start bit, data bits LSB first, one stop bit. Strobes while busy are dropped.
 */
module uart_tx #(
    parameter int unsigned DATA_BITS = uart_cfg_pkg::UART_DEFAULT_DATA_BITS
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_i,
    input  logic [DATA_BITS-1:0]      data_i,
    input  uart_cfg_pkg::baud_div_t   baud_div_i,
    output logic                      tx_o,
    output logic                      busy_o
);
    import uart_cfg_pkg::*;
    import uart_state_pkg::*;

    uart_tx_state_e        state_ff, state_next;
    baud_div_t             cnt_ff, cnt_next;
    bit_cnt_t              bit_cnt_ff, bit_cnt_next;
    logic [DATA_BITS-1:0]  shift_ff, shift_next;
    logic                  tx_ff, tx_next;
    logic                  bit_end;

    // Last cycle of the current bit period
    assign bit_end = (cnt_ff == baud_div_t'(1));

    always_comb begin
        state_next   = state_ff;
        cnt_next     = cnt_ff - 1'b1;
        bit_cnt_next = bit_cnt_ff;
        shift_next   = shift_ff;
        tx_next      = tx_ff;

        case (state_ff)
            TX_IDLE: begin
                cnt_next = cnt_ff;
                tx_next  = 1'b1;
                if (start_i) begin
                    state_next = TX_START;
                    shift_next = data_i;
                    cnt_next   = baud_div_i;
                    tx_next    = 1'b0;
                end
            end

            TX_START: begin
                if (bit_end) begin
                    state_next   = TX_DATA;
                    cnt_next     = baud_div_i;
                    bit_cnt_next = bit_cnt_t'(DATA_BITS);
                    tx_next      = shift_ff[0];
                    shift_next   = {1'b0, shift_ff[DATA_BITS-1:1]};
                end
            end

            TX_DATA: begin
                if (bit_end) begin
                    cnt_next     = baud_div_i;
                    bit_cnt_next = bit_cnt_ff - 1'b1;
                    if (bit_cnt_ff == bit_cnt_t'(1)) begin
                        state_next = TX_STOP;
                        tx_next    = 1'b1;
                    end else begin
                        tx_next    = shift_ff[0];
                        shift_next = {1'b0, shift_ff[DATA_BITS-1:1]};
                    end
                end
            end

            TX_STOP: begin
                // Line is already high, just hold it for one bit time
                if (bit_end) begin
                    state_next = TX_IDLE;
                end
            end

            default: begin
                state_next = TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_ff   <= TX_IDLE;
            cnt_ff     <= '0;
            bit_cnt_ff <= '0;
            tx_ff      <= 1'b1;
        end else begin
            state_ff   <= state_next;
            cnt_ff     <= cnt_next;
            bit_cnt_ff <= bit_cnt_next;
            tx_ff      <= tx_next;
        end
    end

    // Outgoing word, loaded on an accepted start
    always_ff @(posedge clk) begin
        shift_ff <= shift_next;
    end

    assign tx_o   = tx_ff;
    assign busy_o = (state_ff != TX_IDLE);

endmodule

// ==== source/uart_rx.sv ====
/*
 * UART receiver. Finds the start bit, samples each bit mid-period and
 * checks the stop bit, then pulses valid_o or frame_err_o for one cycle.
 */
module uart_rx #(
    parameter int unsigned DATA_BITS = uart_cfg_pkg::UART_DEFAULT_DATA_BITS
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rx_i,
    input  uart_cfg_pkg::baud_div_t   baud_div_i,
    output logic [DATA_BITS-1:0]      rx_data_o,
    output logic                      valid_o,
    output logic                      frame_err_o
);
    import uart_cfg_pkg::*;
    import uart_state_pkg::*;

    logic                  rx_meta;
    logic                  rx_sync;

    uart_rx_state_e        state_ff, state_next;
    baud_div_t             sample_cnt_ff, sample_cnt_next;
    baud_div_t             mid_cnt_ff, mid_cnt_next;
    bit_cnt_t              bit_cnt_ff, bit_cnt_next;
    logic [DATA_BITS-1:0]  shift_ff, shift_next;
    logic                  valid_ff, valid_next;
    logic                  frame_err_ff, frame_err_next;

    baud_div_t             half_div;
    logic                  sample_pulse;
    logic                  mid_point;

    // Two-flop synchronizer on the incoming line
    always_ff @(posedge clk) begin
        rx_meta <= rx_i;
        rx_sync <= rx_meta;
    end

    assign half_div     = baud_div_i >> 1;
    assign sample_pulse = (sample_cnt_ff == baud_div_t'(1));
    // Middle of the start bit, counted from the first low sample
    assign mid_point    = (mid_cnt_ff == half_div);

    always_comb begin
        state_next      = state_ff;
        sample_cnt_next = sample_cnt_ff;
        mid_cnt_next    = mid_cnt_ff;
        bit_cnt_next    = bit_cnt_ff;
        shift_next      = shift_ff;
        valid_next      = 1'b0;
        frame_err_next  = 1'b0;

        case (state_ff)
            RX_IDLE: begin
                mid_cnt_next = '0;
                if (!rx_sync) begin
                    state_next = RX_START;
                end
            end

            RX_START: begin
                if (mid_point) begin
                    // Line back high at mid-point means a glitch, not a start
                    if (rx_sync) begin
                        state_next = RX_IDLE;
                    end else begin
                        state_next      = RX_DATA;
                        sample_cnt_next = baud_div_i;
                        bit_cnt_next    = bit_cnt_t'(DATA_BITS);
                    end
                end else begin
                    mid_cnt_next = mid_cnt_ff + 1'b1;
                end
            end

            RX_DATA: begin
                if (sample_pulse) begin
                    sample_cnt_next = baud_div_i;
                    // LSB arrives first, so shift in at the top
                    shift_next      = {rx_sync, shift_ff[DATA_BITS-1:1]};
                    bit_cnt_next    = bit_cnt_ff - 1'b1;
                    if (bit_cnt_ff == bit_cnt_t'(1)) begin
                        state_next = RX_STOP;
                    end
                end else begin
                    sample_cnt_next = sample_cnt_ff - 1'b1;
                end
            end

            RX_STOP: begin
                if (sample_pulse) begin
                    state_next = RX_IDLE;
                    if (rx_sync) begin
                        valid_next = 1'b1;
                    end else begin
                        frame_err_next = 1'b1;
                    end
                end else begin
                    sample_cnt_next = sample_cnt_ff - 1'b1;
                end
            end

            default: begin
                state_next = RX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_ff      <= RX_IDLE;
            sample_cnt_ff <= '0;
            mid_cnt_ff    <= '0;
            bit_cnt_ff    <= '0;
            valid_ff      <= 1'b0;
            frame_err_ff  <= 1'b0;
        end else begin
            state_ff      <= state_next;
            sample_cnt_ff <= sample_cnt_next;
            mid_cnt_ff    <= mid_cnt_next;
            bit_cnt_ff    <= bit_cnt_next;
            valid_ff      <= valid_next;
            frame_err_ff  <= frame_err_next;
        end
    end

    // Data shifter
    always_ff @(posedge clk) begin
        shift_ff <= shift_next;
    end

    assign rx_data_o   = shift_ff;
    assign valid_o     = valid_ff;
    assign frame_err_o = frame_err_ff;

endmodule

// ==== common/uart_state_pkg.sv ====
/*
 * FSM encodings for both UART halves and the status word layout.
 */
package uart_state_pkg;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE  = 2'b00,
        RX_START = 2'b01,
        RX_DATA  = 2'b10,
        RX_STOP  = 2'b11
    } uart_rx_state_e;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE  = 2'b00,
        TX_START = 2'b01,
        TX_DATA  = 2'b10,
        TX_STOP  = 2'b11
    } uart_tx_state_e;

    // Status word seen by the host
    typedef struct packed {
        // Holding register has an unread word
        logic rx_ready;
        // A word arrived while the previous one was unread
        logic overrun;
        // Stop bit was sampled low
        logic frame_err;
        // Transmitter is sending a frame
        logic tx_busy;
    } uart_status_t;

endpackage

// ==== common/uart_cfg_pkg.sv ====
/*
 * Width and type definitions for the UART datapath.
 * Import wherever divisor or bit counters are declared.
 */
package uart_cfg_pkg;

    // Baud divisor, given in clock cycles per bit
    localparam int unsigned UART_DIV_W = 16;

    // Data bit counter, wide enough for up to 15 bits
    localparam int unsigned UART_BIT_CNT_W = 4;

    // Word width used when the top level is not overridden
    localparam int unsigned UART_DEFAULT_DATA_BITS = 8;

    // Cycles per bit, also used for the sample counters
    typedef logic [UART_DIV_W-1:0] baud_div_t;

    // Data bits still to go in the current frame
    typedef logic [UART_BIT_CNT_W-1:0] bit_cnt_t;

endpackage
